// ==== hdl/epu_pkg.sv ====
`default_nettype none

package epu_pkg;

  localparam int DEF_ADDR_W = 10;
  localparam int DATA_W     = 16;
  localparam int RESULT_W   = 32;

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [RESULT_W-1:0] result_t;  // sums wrap modulo 2**32.

  typedef enum logic [1:0] {
    OP_WRITE = 2'd0,
    OP_READ  = 2'd1,
    OP_START = 2'd2
  } host_op_e;

  // for a start command the wdata field carries the vector length.
  typedef struct packed {
    host_op_e              op;
    logic [DEF_ADDR_W-1:0] addr;
    data_t                 wdata;
  } host_cmd_t;

  typedef struct packed {
    result_t rdata;
  } host_rsp_t;

  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic [DEF_ADDR_W-1:0] addr;
    data_t                 wdata;
  } sram_req_t;

  typedef enum logic [1:0] {
    BUF_IDLE    = 2'd0,
    BUF_ENGINE  = 2'd1,
    BUF_HOST_RD = 2'd2,
    BUF_HOST_WR = 2'd3
  } buf_state_e;

endpackage

`default_nettype wire

// ==== hdl/sram_bank.sv ====
`default_nettype none

module sram_bank #(
  parameter int ADDR_W = epu_pkg::DEF_ADDR_W
) (
  input  logic               clk,
  input  epu_pkg::sram_req_t mem_i,
  output epu_pkg::data_t     rdata_o
);

  import epu_pkg::*;

  data_t             mem_q [2**ADDR_W];
  logic [ADDR_W-1:0] addr;

  assign addr = mem_i.addr[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (mem_i.cs) begin
      if (mem_i.we) begin
        mem_q[addr] <= mem_i.wdata;
      end else begin
        rdata_o <= mem_q[addr];  // data is seen one cycle after the request.
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/host_port.sv ====
`default_nettype none

module host_port #(
  parameter int ADDR_W = epu_pkg::DEF_ADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_i,
  input  epu_pkg::host_cmd_t cmd_i,
  output logic               ack_o,
  output epu_pkg::host_rsp_t rsp_o,
  output epu_pkg::sram_req_t host_mem_o,
  input  logic               host_rvalid_i,
  input  epu_pkg::data_t     host_rdata_i,
  output logic               job_req_o,
  output epu_pkg::data_t     job_len_o,
  input  logic               job_ack_i,
  input  epu_pkg::result_t   job_result_i
);

  import epu_pkg::*;

  typedef enum logic [2:0] {
    HP_IDLE    = 3'd0,
    HP_ISSUE   = 3'd1,
    HP_WAIT_RD = 3'd2,
    HP_RUN     = 3'd3,
    HP_ACK     = 3'd4,
    HP_RELEASE = 3'd5
  } hp_state_e;

  hp_state_e         state_q;
  host_cmd_t         cmd_q;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_cs;

  assign mem_addr = cmd_q.addr[ADDR_W-1:0];
  assign mem_cs   = (state_q == HP_ISSUE) && (cmd_q.op inside {OP_WRITE, OP_READ});

  // a single-cycle access, driven only while the FSM sits in issue.
  assign host_mem_o = '{
    cs:    mem_cs,
    we:    (cmd_q.op == OP_WRITE),
    addr:  DEF_ADDR_W'(mem_addr),
    wdata: cmd_q.wdata
  };

  assign job_len_o = cmd_q.wdata;  // cmd_q holds still for the whole job.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= HP_IDLE;
      ack_o     <= 1'b0;
      job_req_o <= 1'b0;
    end else begin
      case (state_q)
        HP_IDLE: begin
          if (req_i) begin
            state_q <= HP_ISSUE;
          end
        end
        HP_ISSUE: begin
          case (cmd_q.op)
            OP_WRITE: state_q <= HP_ACK;
            OP_READ:  state_q <= HP_WAIT_RD;
            OP_START: begin
              job_req_o <= 1'b1;
              state_q   <= HP_RUN;
            end
            default:  state_q <= HP_ACK;  // unknown opcodes answer with zero.
          endcase
        end
        HP_WAIT_RD: begin
          if (host_rvalid_i) begin
            state_q <= HP_ACK;
          end
        end
        HP_RUN: begin
          if (job_req_o && job_ack_i) begin
            job_req_o <= 1'b0;
          end else if (!job_req_o && !job_ack_i) begin
            state_q <= HP_ACK;  // engine handshake fully closed.
          end
        end
        // rsp_o settles here, one cycle ahead of ack.
        HP_ACK: state_q <= HP_RELEASE;
        HP_RELEASE: begin
          if (!ack_o) begin
            ack_o <= 1'b1;
          end else if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= HP_IDLE;
          end
        end
        default: state_q <= HP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == HP_IDLE && req_i) begin
      cmd_q <= cmd_i;
    end
    case (state_q)
      HP_ISSUE: rsp_o.rdata <= '0;
      HP_WAIT_RD: begin
        if (host_rvalid_i) begin
          rsp_o.rdata <= result_t'(host_rdata_i);  // zero-extended word.
        end
      end
      HP_RUN: begin
        if (job_req_o && job_ack_i) begin
          rsp_o.rdata <= job_result_i;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/input_buffer.sv ====
`default_nettype none

module input_buffer #(
  parameter int ADDR_W = epu_pkg::DEF_ADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               job_req_i,
  input  logic               job_ack_i,
  input  epu_pkg::sram_req_t host_mem_i,
  output logic               host_rvalid_o,
  output epu_pkg::data_t     host_rdata_o,
  input  epu_pkg::sram_req_t eng_mem_i,
  output epu_pkg::data_t     eng_rdata_o
);

  import epu_pkg::*;

  buf_state_e state_q;
  buf_state_e state_d;
  sram_req_t  sram_req;
  data_t      sram_rdata;

  sram_bank #(
    .ADDR_W (ADDR_W)
  ) u_sram (
    .clk     (clk),
    .mem_i   (sram_req),
    .rdata_o (sram_rdata)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= BUF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      BUF_IDLE: begin
        if (job_req_i) begin
          state_d = BUF_ENGINE;  // a job wins over any host access.
        end else if (host_mem_i.cs && !host_mem_i.we) begin
          state_d = BUF_HOST_RD;
        end else if (host_mem_i.cs && host_mem_i.we) begin
          state_d = BUF_HOST_WR;
        end
      end
      BUF_ENGINE: begin
        // the engine keeps the port from request until both handshake lines are low.
        if (!job_req_i && !job_ack_i) begin
          state_d = BUF_IDLE;
        end
      end
      BUF_HOST_RD: state_d = BUF_IDLE;
      BUF_HOST_WR: state_d = BUF_IDLE;
      default:     state_d = BUF_IDLE;
    endcase
  end

  always_comb begin
    sram_req      = host_mem_i;
    eng_rdata_o   = '0;
    host_rdata_o  = '0;
    host_rvalid_o = 1'b0;
    case (state_q)
      BUF_ENGINE: begin
        sram_req    = eng_mem_i;
        eng_rdata_o = sram_rdata;
      end
      BUF_HOST_RD: begin
        host_rvalid_o = 1'b1;  // the word read last cycle is on the SRAM output now.
        host_rdata_o  = sram_rdata;
      end
      default: ;  // idle and write states leave the port with the host.
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/dot_engine.sv ====
`default_nettype none

module dot_engine #(
  parameter int ADDR_W = epu_pkg::DEF_ADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               job_req_i,
  input  epu_pkg::data_t     job_len_i,
  output logic               job_ack_o,
  output epu_pkg::result_t   job_result_o,
  output epu_pkg::sram_req_t mem_o,
  input  epu_pkg::data_t     rdata_i
);

  import epu_pkg::*;

  typedef enum logic [1:0] {
    ENG_IDLE  = 2'd0,
    ENG_RUN   = 2'd1,
    ENG_DRAIN = 2'd2,
    ENG_DONE  = 2'd3
  } eng_state_e;

  eng_state_e        state_q;
  data_t             len_q;
  data_t             idx_q;
  logic              b_phase_q;  // set when the next read fetches a B word.
  logic              issue;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_vld_q;
  logic              rd_is_b_q;
  data_t             a_q;
  result_t           prod_q;
  logic              prod_vld_q;
  result_t           acc_q;

  assign issue   = (state_q == ENG_RUN) && (idx_q != len_q);
  assign rd_addr = {b_phase_q, idx_q[ADDR_W-2:0]};  // B sits in the upper half.

  assign mem_o = '{
    cs:    issue,
    we:    1'b0,
    addr:  DEF_ADDR_W'(rd_addr),
    wdata: '0
  };

  assign job_result_o = acc_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= ENG_IDLE;
      job_ack_o  <= 1'b0;
      idx_q      <= '0;
      b_phase_q  <= 1'b0;
      rd_vld_q   <= 1'b0;
      prod_vld_q <= 1'b0;
    end else begin
      rd_vld_q   <= issue;
      prod_vld_q <= rd_vld_q && rd_is_b_q;
      case (state_q)
        ENG_IDLE: begin
          if (job_req_i) begin
            idx_q     <= '0;
            b_phase_q <= 1'b0;
            state_q   <= ENG_RUN;
          end
        end
        ENG_RUN: begin
          if (issue) begin
            b_phase_q <= !b_phase_q;
            if (b_phase_q) begin
              idx_q <= idx_q + 1'b1;
            end
          end else begin
            state_q <= ENG_DRAIN;
          end
        end
        ENG_DRAIN: begin
          // wait for the last B word and its product to reach the sum.
          if (!rd_vld_q && !prod_vld_q) begin
            job_ack_o <= 1'b1;
            state_q   <= ENG_DONE;
          end
        end
        ENG_DONE: begin
          if (!job_req_i) begin
            job_ack_o <= 1'b0;
            state_q   <= ENG_IDLE;
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rd_is_b_q <= b_phase_q;
    if (state_q == ENG_IDLE && job_req_i) begin
      len_q <= job_len_i;
      acc_q <= '0;
    end else if (prod_vld_q) begin
      acc_q <= acc_q + prod_q;
    end
    if (rd_vld_q) begin
      if (rd_is_b_q) begin
        prod_q <= result_t'(a_q) * result_t'(rdata_i);
      end else begin
        a_q <= rdata_i;  // hold A until its partner arrives.
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/epu_input_top.sv ====
`default_nettype none

module epu_input_top #(
  parameter int ADDR_W = epu_pkg::DEF_ADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_i,
  input  epu_pkg::host_cmd_t cmd_i,
  output logic               ack_o,
  output epu_pkg::host_rsp_t rsp_o
);

  import epu_pkg::*;

  sram_req_t host_mem;
  logic      host_rvalid;
  data_t     host_rdata;
  sram_req_t eng_mem;
  data_t     eng_rdata;
  logic      job_req;
  data_t     job_len;
  logic      job_ack;
  result_t   job_result;

  host_port #(
    .ADDR_W (ADDR_W)
  ) u_host_port (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req_i),
    .cmd_i         (cmd_i),
    .ack_o         (ack_o),
    .rsp_o         (rsp_o),
    .host_mem_o    (host_mem),
    .host_rvalid_i (host_rvalid),
    .host_rdata_i  (host_rdata),
    .job_req_o     (job_req),
    .job_len_o     (job_len),
    .job_ack_i     (job_ack),
    .job_result_i  (job_result)
  );

  input_buffer #(
    .ADDR_W (ADDR_W)
  ) u_input_buffer (
    .clk           (clk),
    .rst           (rst),
    .job_req_i     (job_req),
    .job_ack_i     (job_ack),
    .host_mem_i    (host_mem),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .eng_mem_i     (eng_mem),
    .eng_rdata_o   (eng_rdata)
  );

  dot_engine #(
    .ADDR_W (ADDR_W)
  ) u_dot_engine (
    .clk          (clk),
    .rst          (rst),
    .job_req_i    (job_req),
    .job_len_i    (job_len),
    .job_ack_o    (job_ack),
    .job_result_o (job_result),
    .mem_o        (eng_mem),
    .rdata_i      (eng_rdata)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_epu_input.sv ====
`default_nettype none

module tb_epu_input;

  import epu_pkg::*;

  localparam int    TIMEOUT_CYCLES = 200;
  localparam int    HOLD_CYCLES    = 3;
  localparam string PATTERN_FILE   = "testbench/epu_input_patterns.txt";

  logic      clk;
  logic      rst;
  logic      req_i;
  host_cmd_t cmd_i;
  logic      ack_o;
  host_rsp_t rsp_o;

  int checks;
  int mismatches;
  int failures;  // timeouts and file problems.

  epu_input_top #(
    .ADDR_W (DEF_ADDR_W)
  ) u_dut (
    .clk   (clk),
    .rst   (rst),
    .req_i (req_i),
    .cmd_i (cmd_i),
    .ack_o (ack_o),
    .rsp_o (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // outputs are looked at on the falling edge, well away from the driving edge.
  task automatic wait_ack(input logic level, input string what, output int cycles,
                          output bit seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (ack_o === level) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("Timeout at %0t: ack_o did not go %0b within %0d cycles while waiting for %s.",
               $time, level, TIMEOUT_CYCLES, what);
      failures++;
    end
  endtask

  // one full four-phase transfer on the host port.
  task automatic run_command(input int op, input int addr, input int data,
                             output result_t rsp, output bit done);
    int cycles;
    int latency;
    int want_latency;
    bit seen;
    done = 1'b0;
    rsp  = '0;
    @(posedge clk);
    cmd_i <= '{op: host_op_e'(op[1:0]), addr: addr[DEF_ADDR_W-1:0], wdata: data[15:0]};
    req_i <= 1'b1;
    wait_ack(1'b1, "command completion", cycles, seen);
    if (!seen) begin
      @(posedge clk);
      req_i <= 1'b0;
    end else begin
      rsp = rsp_o.rdata;
      // the first falling edge comes half a cycle before req_i is sampled.
      latency = cycles - 2;
      if (op < 2) begin
        want_latency = (op == 0) ? 3 : 4;
        checks++;
        if (latency != want_latency) begin
          $display("Mismatch at %0t: op %0d ack latency expected %0d got %0d cycles",
                   $time, op, want_latency, latency);
          mismatches++;
        end
      end
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        checks++;
        if (ack_o !== 1'b1) begin
          $display("Mismatch at %0t: ack_o expected 1 while req_i is held, got %b",
                   $time, ack_o);
          mismatches++;
        end
      end
      @(posedge clk);
      req_i <= 1'b0;
      wait_ack(1'b0, "ack_o release after req_i fell", cycles, seen);
      done = seen;
    end
  endtask

  initial begin : main
    int      fd;
    int      got;
    int      line_no;
    int      patterns;
    int      op;
    int      addr;
    int      data;
    string   line;
    string   exp_s;
    result_t exp_val;
    result_t rsp;
    bit      done;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    line_no    = 0;
    patterns   = 0;
    rst        = 1'b1;
    req_i      = 1'b0;
    cmd_i      = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checks++;
    if (ack_o !== 1'b0) begin
      $display("Mismatch at %0t: ack_o after reset expected 0 got %b", $time, ack_o);
      mismatches++;
    end

    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s.", PATTERN_FILE);
      failures++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got  = $fgets(line, fd);
        line_no++;
        if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%h %h %h %s", op, addr, data, exp_s);
          if (got != 4) begin
            $display("Pattern line %0d could not be parsed.", line_no);
            failures++;
          end else begin
            patterns++;
            run_command(op, addr, data, rsp, done);
            if (done && exp_s != "-") begin  // a dash marks a response nobody checks.
              got = $sscanf(exp_s, "%h", exp_val);
              checks++;
              if (rsp !== exp_val) begin
                $display("Mismatch at %0t: line %0d op %0d addr %h expected %h got %h",
                         $time, line_no, op, addr[DEF_ADDR_W-1:0], exp_val, rsp);
                mismatches++;
              end
            end
          end
        end
      end
      $fclose(fd);
      if (patterns == 0) begin
        $display("The pattern file held no commands.");
        failures++;
      end
    end

    $display("patterns %0d, checks %0d, mismatches %0d, other failures %0d",
             patterns, checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/epu_input_patterns.txt ====
# columns: op addr data expected, all hex; op 0 = write, 1 = read, 2 = start
# a start carries the vector length in data; expected "-" is not checked
0 000 0003 -
0 001 0005 -
0 002 0007 -
0 003 0002 -
0 200 0004 -
0 201 0006 -
0 202 0001 -
0 203 0009 -
0 1ff a5a5 -
0 3ff 5a5a -
1 000 0000 00000003
1 003 0000 00000002
1 1ff 0000 0000a5a5
1 200 0000 00000004
1 3ff 0000 00005a5a
2 000 0004 00000043
2 000 0002 0000002a
2 000 0000 00000000
2 000 0001 0000000c
1 000 0000 00000003
1 001 0000 00000005
1 201 0000 00000006
1 203 0000 00000009
0 000 ffff -
0 001 ffff -
0 002 ffff -
0 200 ffff -
0 201 ffff -
0 202 ffff -
2 000 0004 fffa0015
2 000 0003 fffa0003
1 002 0000 0000ffff
1 202 0000 0000ffff
1 003 0000 00000002

// ==== compile.f ====
hdl/epu_pkg.sv
hdl/sram_bank.sv
hdl/host_port.sv
hdl/input_buffer.sv
hdl/dot_engine.sv
hdl/epu_input_top.sv
testbench/tb_epu_input.sv
